// File: camera_pkg.sv
/* Widths, CSI-2 data-type codes, queue depths and the structs of the capture front end.
   Imported by every RTL module and by the testbench */
package camera_pkg;

    localparam int pixel_width = 10;
    localparam int coord_width = 11;

    localparam logic [5:0] dt_frame_start = 6'h00;
    localparam logic [5:0] dt_frame_end   = 6'h01;
    localparam logic [5:0] dt_raw10       = 6'h2B;

    localparam int header_bytes      = 4;  // DI, WC low, WC high, ECC
    localparam int footer_bytes      = 2;  // Payload CRC, skipped
    localparam int raw10_group_bytes = 5;

    localparam int pixel_fifo_depth = 16;  // Also the pixel consumer credit limit
    localparam int meter_fifo_depth = 2;

    typedef struct packed {
        logic [coord_width-1:0] x_start;
        logic [coord_width-1:0] y_start;
        logic [coord_width-1:0] width;
        logic [coord_width-1:0] height;
    } crop_window_t;

    typedef struct packed {
        logic [pixel_width-1:0] pixel;
        logic                   first;  // Window origin of the frame
        logic                   last;   // Final x of a window row
    } pixel_beat_t;

    typedef struct packed {
        logic [31:0]            sum;
        logic [pixel_width-1:0] peak;
        logic [21:0]            count;
        logic                   error;  // Word count not a multiple of five
    } meter_result_t;

    typedef struct packed {
        logic       frame_start;
        logic       frame_end;
        logic       line_start;
        logic       line_end;
        logic       payload_byte_valid;
        logic [7:0] payload_byte;
    } raster_event_t;

endpackage

// File: csi2_packet_fsm.sv
`timescale 1ns/1ps
/* Parses the single-lane CSI-2 byte stream into frame, line and payload events.
   ECC and CRC bytes are skipped unchecked, events come one cycle after their byte */
module csi2_packet_fsm (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  logic [7:0]                byte_i,
    input  logic                      byte_valid_i,
    output camera_pkg::raster_event_t event_o,
    output logic                      wc_error_o
);
    import camera_pkg::*;

    typedef enum logic [1:0] {
        st_header,
        st_payload,
        st_footer
    } state_t;

    state_t      state;
    logic [2:0]  byte_count;    // Index inside header or footer
    logic [5:0]  data_type;
    logic [15:0] word_count;
    logic [15:0] payload_left;
    logic        is_raw10;      // Payload of this packet carries pixels
    logic        wc_bad;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state        <= st_header;
            byte_count   <= '0;
            data_type    <= '0;
            word_count   <= '0;
            payload_left <= '0;
            is_raw10     <= 1'b0;
            wc_bad       <= 1'b0;
            event_o      <= '0;
            wc_error_o   <= 1'b0;
        end else begin
            event_o              <= '0;  // Strobes last one cycle
            event_o.payload_byte <= byte_i;
            wc_error_o           <= 1'b0;
            if (byte_valid_i) begin
                case (state)
                    st_header: begin
                        if (byte_count == 3'(header_bytes - 1)) begin
                            byte_count <= '0;  // ECC byte closes the header
                            if (data_type[5:4] == 2'b00) begin
                                event_o.frame_start <= (data_type == dt_frame_start);
                                event_o.frame_end   <= (data_type == dt_frame_end);
                            end else begin
                                is_raw10           <= (data_type == dt_raw10);
                                wc_bad             <= (word_count % raw10_group_bytes) != 0;
                                payload_left       <= word_count;
                                event_o.line_start <= (data_type == dt_raw10);
                                if (word_count == 16'd0) begin
                                    event_o.line_end <= (data_type == dt_raw10);
                                    state            <= st_footer;
                                end else begin
                                    state <= st_payload;
                                end
                            end
                        end else begin
                            byte_count <= byte_count + 3'd1;
                            case (byte_count)
                                3'd0:    data_type <= byte_i[5:0];  // VC bits dropped
                                3'd1:    word_count[7:0] <= byte_i;
                                default: word_count[15:8] <= byte_i;
                            endcase
                        end
                    end
                    st_payload: begin
                        payload_left               <= payload_left - 16'd1;
                        event_o.payload_byte_valid <= is_raw10;  // Other types skipped
                        if (payload_left == 16'd1) begin
                            event_o.line_end <= is_raw10;
                            wc_error_o       <= is_raw10 && wc_bad;
                            state            <= st_footer;
                        end
                    end
                    st_footer: begin
                        byte_count <= byte_count + 3'd1;
                        if (byte_count == 3'(footer_bytes - 1)) begin
                            byte_count <= '0;
                            state      <= st_header;
                        end
                    end
                    default: state <= st_header;
                endcase
            end
        end
    end

endmodule

// File: raw10_unpacker.sv
`timescale 1ns/1ps
/* Unpacks five-byte RAW10 groups into four 10-bit pixels, one per cycle.
   A partial group left at the end of a line is dropped at the next line start */
module raw10_unpacker (
    input  logic                              mipi_byte_clock,
    input  logic                              mipi_byte_reset_n,
    input  camera_pkg::raster_event_t         event_i,
    output logic                              pixel_valid_o,
    output logic [camera_pkg::pixel_width-1:0] pixel_o
);
    import camera_pkg::*;

    logic [2:0]       byte_index;
    logic [3:0][7:0]  upper;          // High bits of pixels 0 to 3
    logic [23:0]      pending_hi;     // Pixels 1 to 3 still to emit
    logic [5:0]       pending_lo;
    logic [1:0]       pending_count;
    logic             group_done;

    assign group_done = event_i.payload_byte_valid &&
                        (byte_index == 3'(raw10_group_bytes - 1));

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            byte_index    <= '0;
            pixel_valid_o <= 1'b0;
            pending_count <= '0;
        end else begin
            if (event_i.line_start || group_done) begin
                byte_index <= '0;
            end else if (event_i.payload_byte_valid) begin
                byte_index <= byte_index + 3'd1;
            end
            if (group_done) begin
                pixel_valid_o <= 1'b1;
                pending_count <= 2'd3;
            end else if (pending_count != 2'd0) begin
                pixel_valid_o <= 1'b1;
                pending_count <= pending_count - 2'd1;
            end else begin
                pixel_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (event_i.payload_byte_valid && !group_done) begin
            upper[byte_index[1:0]] <= event_i.payload_byte;
        end
        if (group_done) begin
            pixel_o    <= {upper[0], event_i.payload_byte[1:0]};  // Pixel 0 low bits at 1:0
            pending_hi <= {upper[3], upper[2], upper[1]};
            pending_lo <= event_i.payload_byte[7:2];
        end else if (pending_count != 2'd0) begin
            pixel_o    <= {pending_hi[7:0], pending_lo[1:0]};
            pending_hi <= pending_hi >> 8;
            pending_lo <= pending_lo >> 2;
        end
    end

endmodule

// File: raster_counter.sv
`timescale 1ns/1ps
/* Places each pixel on the x/y raster and keeps only those inside the crop window.
   The window is sampled at frame start, beats come out one cycle after the pixel */
module raster_counter (
    input  logic                               mipi_byte_clock,
    input  logic                               mipi_byte_reset_n,
    input  camera_pkg::raster_event_t          event_i,
    input  camera_pkg::crop_window_t           crop_window_i,
    input  logic                               pixel_valid_i,
    input  logic [camera_pkg::pixel_width-1:0] pixel_i,
    output logic                               beat_valid_o,
    output camera_pkg::pixel_beat_t            beat_o
);
    import camera_pkg::*;

    crop_window_t           window;
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;
    logic                   line_done;  // Line ended, y moves on at next line start
    logic [coord_width:0]   x_end;      // Exclusive bounds
    logic [coord_width:0]   y_end;
    logic                   in_window;

    assign x_end     = window.x_start + window.width;
    assign y_end     = window.y_start + window.height;
    assign in_window = (x >= window.x_start) && ({1'b0, x} < x_end) &&
                       (y >= window.y_start) && ({1'b0, y} < y_end);

    // Trailing pixels of a group arrive after line end, so y steps on the next line start
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            window       <= '0;
            x            <= '0;
            y            <= '0;
            line_done    <= 1'b0;
            beat_valid_o <= 1'b0;
        end else begin
            if (event_i.frame_start) begin
                window    <= crop_window_i;
                y         <= '0;
                line_done <= 1'b0;
            end
            if (event_i.line_start) begin
                x         <= '0;
                line_done <= 1'b0;
                if (line_done) begin
                    y <= y + 1'b1;
                end
            end else if (pixel_valid_i) begin
                x <= x + 1'b1;
            end
            if (event_i.line_end) begin
                line_done <= 1'b1;
            end
            beat_valid_o <= pixel_valid_i && in_window;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        beat_o.pixel <= pixel_i;
        beat_o.first <= (x == window.x_start) && (y == window.y_start);
        beat_o.last  <= ({1'b0, x} == x_end - 1'b1);
    end

endmodule

// File: frame_metering.sv
`timescale 1ns/1ps
/* Sum, peak and count of the cropped pixels of one frame, with the word-count error.
   One result per frame, valid the cycle after frame end */
module frame_metering (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  camera_pkg::raster_event_t event_i,
    input  logic                      wc_error_i,
    input  logic                      beat_valid_i,
    input  camera_pkg::pixel_beat_t   beat_i,
    output logic                      result_valid_o,
    output camera_pkg::meter_result_t result_o
);
    import camera_pkg::*;

    meter_result_t acc;  // Running totals of the current frame

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            acc            <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= event_i.frame_end;
            if (event_i.frame_start) begin
                acc <= '0;
            end else begin
                if (beat_valid_i) begin
                    acc.sum   <= acc.sum + 32'(beat_i.pixel);
                    acc.count <= acc.count + 22'd1;
                    if (beat_i.pixel > acc.peak) begin
                        acc.peak <= beat_i.pixel;
                    end
                end
                if (wc_error_i) begin
                    acc.error <= 1'b1;  // Held until the next frame start
                end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (event_i.frame_end) begin
            result_o <= acc;
        end
    end

endmodule

// File: credit_fifo.sv
`timescale 1ns/1ps
/* Circular queue that sends its head entry only while it holds a consumer credit.
   A push into a full queue is dropped and raises overflow until clear */
module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     mipi_byte_clock,
    input  logic     mipi_byte_reset_n,
    input  logic     clear_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     credit_i,
    output logic     valid_o,
    output payload_t data_o,
    output logic     overflow_o
);

    payload_t                   mem [depth];
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] used;
    logic [$clog2(depth+1)-1:0] credits;  // Starts at zero after reset
    logic                       full;
    logic                       accept;
    logic                       send;

    assign full   = (used == depth);
    assign accept = push_i && !full;
    assign send   = (used != '0) && (credits != '0);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            used       <= '0;
            credits    <= '0;
            valid_o    <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            valid_o <= send;
            if (accept) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (accept && !send) begin
                used <= used + 1'b1;
            end else if (send && !accept) begin
                used <= used - 1'b1;
            end
            if (credit_i && !send) begin
                credits <= credits + 1'b1;
            end else if (send && !credit_i) begin
                credits <= credits - 1'b1;  // Each send spends one credit
            end
            if (clear_i) begin
                overflow_o <= 1'b0;
            end else if (push_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (accept) begin
            mem[wr_ptr] <= push_data_i;
        end
        if (send) begin
            data_o <= mem[rd_ptr];
        end
    end

endmodule

// File: camera_frontend.sv
`timescale 1ns/1ps
/* Top of the byte-clock capture front end, from CSI-2 bytes to cropped pixels.
   Pixels and per-frame meter results each leave through a credit queue */
module camera_frontend (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  logic [7:0]                byte_i,
    input  logic                      byte_valid_i,
    input  camera_pkg::crop_window_t  crop_window_i,
    output logic                      pix_valid_o,
    output camera_pkg::pixel_beat_t   pix_o,
    input  logic                      pix_credit_i,
    output logic                      meter_valid_o,
    output camera_pkg::meter_result_t meter_o,
    input  logic                      meter_credit_i,
    output logic                      overflow_o
);
    import camera_pkg::*;

    raster_event_t          raster_event;
    logic                   wc_error;
    logic                   pixel_valid;
    logic [pixel_width-1:0] pixel;
    logic                   beat_valid;  // Pixel kept by the crop window
    pixel_beat_t            beat;
    logic                   result_valid;
    meter_result_t          result;

    csi2_packet_fsm packet_fsm (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_i            (byte_i),
        .byte_valid_i      (byte_valid_i),
        .event_o           (raster_event),
        .wc_error_o        (wc_error)
    );

    raw10_unpacker unpacker (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .event_i           (raster_event),
        .pixel_valid_o     (pixel_valid),
        .pixel_o           (pixel)
    );

    raster_counter raster (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .event_i           (raster_event),
        .crop_window_i     (crop_window_i),
        .pixel_valid_i     (pixel_valid),
        .pixel_i           (pixel),
        .beat_valid_o      (beat_valid),
        .beat_o            (beat)
    );

    frame_metering metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .event_i           (raster_event),
        .wc_error_i        (wc_error),
        .beat_valid_i      (beat_valid),
        .beat_i            (beat),
        .result_valid_o    (result_valid),
        .result_o          (result)
    );

    credit_fifo #(
        .payload_t (pixel_beat_t),
        .depth     (pixel_fifo_depth)
    ) pixel_queue (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .clear_i           (raster_event.frame_start),
        .push_i            (beat_valid),
        .push_data_i       (beat),
        .credit_i          (pix_credit_i),
        .valid_o           (pix_valid_o),
        .data_o            (pix_o),
        .overflow_o        (overflow_o)
    );

    // One result per frame, cannot fill while credits come back within a frame
    credit_fifo #(
        .payload_t (meter_result_t),
        .depth     (meter_fifo_depth)
    ) meter_queue (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .clear_i           (raster_event.frame_start),
        .push_i            (result_valid),
        .push_data_i       (result),
        .credit_i          (meter_credit_i),
        .valid_o           (meter_valid_o),
        .data_o            (meter_o),
        .overflow_o        ()
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps
/* Byte clock and active-low reset for the capture front end testbench */
module tb_clock_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 16
) (
    output logic clock_o,
    output logic reset_n_o
);

    initial begin
        clock_o = 1'b0;
        forever #(period_ns / 2.0) clock_o = ~clock_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clock_o);
        @(negedge clock_o);
        reset_n_o = 1'b1;  // Release away from the active edge
    end

endmodule

// File: camera_frontend_chk.sv
`timescale 1ns/1ps
/* Credit rules of the output queues, bound into every credit_fifo instance */
module camera_frontend_chk #(
    parameter int depth = 4
) (
    input logic                       mipi_byte_clock,
    input logic                       mipi_byte_reset_n,
    input logic                       credit_i,
    input logic                       send_i,
    input logic                       valid_i,
    input logic [$clog2(depth+1)-1:0] credits_i
);

    int granted;  // Credits returned minus deliveries seen at the output

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            granted <= 0;
        end else begin
            granted <= granted + int'(credit_i) - int'(valid_i);
        end
    end

    // A delivery needs a credit returned earlier and not yet spent
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        valid_i |-> granted > 0)
        else $error("queue delivered an entry without holding a credit");

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        credits_i <= depth)
        else $error("queue holds more credits than its depth");

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        (credits_i == depth && !send_i) |-> !credit_i)
        else $error("consumer returned a credit beyond the queue depth");

    assert property (@(posedge mipi_byte_clock) !mipi_byte_reset_n |-> !valid_i)
        else $error("queue valid high during reset");

endmodule

bind credit_fifo camera_frontend_chk #(.depth(depth)) credit_chk (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .credit_i          (credit_i),
    .send_i            (send),
    .valid_i           (valid_o),
    .credits_i         (credits)
);

// File: camera_frontend_tb.sv
`timescale 1ns/1ps
/* Testbench of the capture front end. Frames from a table are sent as CSI-2 bytes,
   a reference model predicts the cropped pixels and meter results, consumers check them */
module camera_frontend_tb;
    import camera_pkg::*;

    typedef struct packed {
        int x_start;
        int y_start;
        int width;
        int height;
        int lines;
        int pixels_per_line;  // Multiple of four
        int gap_pct;          // Chance of idle cycles before a byte
        int stall;            // Credit stall in cycles, negative holds the whole frame
        int extra_bytes;      // Tail bytes on line 0
        int embedded;         // Leading non-RAW10 long packet
    } frame_row_t;

    localparam int frame_count = 6;
    localparam frame_row_t frame_table [frame_count] = '{
        '{2, 1,  8, 3, 5, 16,  0,  0, 0, 0},
        '{0, 0, 16, 4, 4, 16, 30, 20, 0, 1},  // Full sensor
        '{4, 2, 12, 2, 4, 16, 10,  0, 3, 0},  // Partial group, right edge
        '{1, 0, 10, 5, 6, 12,  0, -1, 0, 0},  // Overflow
        '{3, 3,  5, 2, 6, 20, 50,  8, 0, 1},
        '{0, 0,  8, 4, 4,  8,  0, -1, 0, 0}   // Exactly fills the pixel queue
    };

    logic          mipi_byte_clock;
    logic          mipi_byte_reset_n;
    logic [7:0]    byte_i;
    logic          byte_valid_i;
    crop_window_t  crop_window_i;
    logic          pix_valid_o;
    pixel_beat_t   pix_o;
    logic          pix_credit_i;
    logic          meter_valid_o;
    meter_result_t meter_o;
    logic          meter_credit_i;
    logic          overflow_o;

    pixel_beat_t   exp_pix [$];
    meter_result_t exp_meter [$];
    int            seed = 14629;
    int            pix_errors = 0;
    int            meter_errors = 0;
    int            flag_errors = 0;
    int            other_errors = 0;
    int            pix_outstanding = 0;    // Credits given minus deliveries seen
    int            meter_outstanding = 0;
    int            stall_left = 0;
    bit            hold_credits = 1'b0;
    bit            timed_out = 1'b0;

    tb_clock_gen #(.period_ns(8.0), .reset_cycles(16)) clock_gen (
        .clock_o   (mipi_byte_clock),
        .reset_n_o (mipi_byte_reset_n)
    );

    camera_frontend DUT (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_i            (byte_i),
        .byte_valid_i      (byte_valid_i),
        .crop_window_i     (crop_window_i),
        .pix_valid_o       (pix_valid_o),
        .pix_o             (pix_o),
        .pix_credit_i      (pix_credit_i),
        .meter_valid_o     (meter_valid_o),
        .meter_o           (meter_o),
        .meter_credit_i    (meter_credit_i),
        .overflow_o        (overflow_o)
    );

    task automatic check_pixel(input pixel_beat_t got, input pixel_beat_t exp);
        if (got !== exp) begin
            pix_errors++;
            $display("mismatch at %0t ns: pix_o got pixel %0d first %0b last %0b, expected %0d %0b %0b",
                     $time, got.pixel, got.first, got.last, exp.pixel, exp.first, exp.last);
        end
    endtask

    task automatic check_meter(input meter_result_t got, input meter_result_t exp);
        if (got !== exp) begin
            meter_errors++;
            $display("mismatch at %0t ns: meter_o got sum %0d peak %0d count %0d error %0b",
                     $time, got.sum, got.peak, got.count, got.error);
            $display("    expected sum %0d peak %0d count %0d error %0b",
                     exp.sum, exp.peak, exp.count, exp.error);
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("mismatch at %0t ns: overflow_o got %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic send_byte(input logic [7:0] value, input int gap_pct);
        int idle;
        idle = 0;
        while (idle < 6 && (($random(seed) & 32'h7fff_ffff) % 100) < gap_pct) begin
            @(negedge mipi_byte_clock);
            byte_valid_i = 1'b0;
            idle++;
        end
        @(negedge mipi_byte_clock);
        byte_i       = value;
        byte_valid_i = 1'b1;
    endtask

    task automatic send_header(input logic [5:0] dt, input logic [15:0] wc, input int gap_pct);
        send_byte({2'b00, dt}, gap_pct);
        send_byte(wc[7:0], gap_pct);
        send_byte(wc[15:8], gap_pct);
        send_byte(8'($random(seed)), gap_pct);  // ECC, not checked
    endtask

    task automatic send_long(input logic [5:0] dt, input logic [7:0] payload [$],
                             input int gap_pct);
        send_header(dt, 16'(payload.size()), gap_pct);
        foreach (payload[i]) send_byte(payload[i], gap_pct);
        send_byte(8'($random(seed)), gap_pct);  // CRC
        send_byte(8'($random(seed)), gap_pct);
    endtask

    // Pixel consumer with at most one queue depth of credits out
    always @(negedge mipi_byte_clock) begin
        pix_credit_i = 1'b0;
        if (mipi_byte_reset_n) begin
            if (pix_valid_o) begin
                pix_outstanding--;
                if (exp_pix.size() == 0) begin
                    other_errors++;
                    $display("pix_o delivered an unexpected pixel at %0t ns", $time);
                end else begin
                    check_pixel(pix_o, exp_pix.pop_front());
                end
            end
            if (stall_left > 0) begin
                stall_left--;
            end else if (!hold_credits && pix_outstanding < pixel_fifo_depth) begin
                pix_credit_i = 1'b1;
                pix_outstanding++;
            end
        end
    end

    always @(negedge mipi_byte_clock) begin
        meter_credit_i = 1'b0;
        if (mipi_byte_reset_n) begin
            if (meter_valid_o) begin
                meter_outstanding--;
                if (exp_meter.size() == 0) begin
                    other_errors++;
                    $display("meter_o delivered an unexpected result at %0t ns", $time);
                end else begin
                    check_meter(meter_o, exp_meter.pop_front());
                end
            end
            if (meter_outstanding < meter_fifo_depth) begin
                meter_credit_i = 1'b1;
                meter_outstanding++;
            end
        end
    end

    task automatic run_frame(input frame_row_t row);
        logic [7:0]             payload [$];
        logic [pixel_width-1:0] px [4];
        pixel_beat_t            beat;
        meter_result_t          meter;
        int                     kept;
        int                     held;
        int                     cycles;

        meter       = '0;
        meter.error = (row.extra_bytes % raw10_group_bytes) != 0;
        kept        = 0;
        @(negedge mipi_byte_clock);
        crop_window_i.x_start = coord_width'(row.x_start);
        crop_window_i.y_start = coord_width'(row.y_start);
        crop_window_i.width   = coord_width'(row.width);
        crop_window_i.height  = coord_width'(row.height);
        @(posedge mipi_byte_clock);
        stall_left   = (row.stall > 0) ? row.stall : 0;
        hold_credits = (row.stall < 0);
        held         = pix_outstanding;  // Credits the pixel queue already holds
        send_header(dt_frame_start, 16'($random(seed)), row.gap_pct);
        if (row.embedded != 0) begin
            repeat (7) payload.push_back(8'($random(seed)));
            send_long(6'h12, payload, row.gap_pct);  // Embedded data, skipped
        end
        for (int y = 0; y < row.lines; y++) begin
            payload.delete();
            for (int x = 0; x < row.pixels_per_line; x++) begin
                px[x % 4]  = pixel_width'($random(seed));
                beat.pixel = px[x % 4];
                beat.first = (x == row.x_start) && (y == row.y_start);
                beat.last  = (x == row.x_start + row.width - 1);
                if (x >= row.x_start && x < row.x_start + row.width &&
                    y >= row.y_start && y < row.y_start + row.height) begin
                    kept++;
                    if (row.stall >= 0 || kept <= held + pixel_fifo_depth) exp_pix.push_back(beat);
                    meter.sum   = meter.sum + 32'(beat.pixel);
                    meter.count = meter.count + 22'd1;
                    if (beat.pixel > meter.peak) meter.peak = beat.pixel;
                end
                payload.push_back(px[x % 4][pixel_width-1:2]);
                if (x % 4 == 3) begin
                    payload.push_back({px[3][1:0], px[2][1:0], px[1][1:0], px[0][1:0]});
                end
            end
            if (y == 0) repeat (row.extra_bytes) payload.push_back(8'($random(seed)));
            send_long(dt_raw10, payload, row.gap_pct);
        end
        exp_meter.push_back(meter);
        send_header(dt_frame_end, 16'($random(seed)), row.gap_pct);
        @(negedge mipi_byte_clock);
        byte_valid_i = 1'b0;
        repeat (8) @(posedge mipi_byte_clock);  // Last beats reach the pixel queue
        hold_credits = 1'b0;
        cycles = 0;
        while ((exp_pix.size() != 0 || exp_meter.size() != 0) && cycles < 2000) begin
            @(posedge mipi_byte_clock);
            cycles++;
        end
        if (exp_pix.size() != 0 || exp_meter.size() != 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout at %0t ns: %0d pixels and %0d meter results never arrived",
                     $time, exp_pix.size(), exp_meter.size());
        end else begin
            check_overflow(overflow_o, (row.stall < 0) && (kept > held + pixel_fifo_depth));
        end
    endtask

    initial begin
        int cycles;
        byte_i         = '0;
        byte_valid_i   = 1'b0;
        crop_window_i  = '0;
        pix_credit_i   = 1'b0;
        meter_credit_i = 1'b0;
        cycles         = 0;
        while (mipi_byte_reset_n !== 1'b1 && cycles < 100) begin
            @(posedge mipi_byte_clock);
            cycles++;
        end
        if (mipi_byte_reset_n !== 1'b1) begin
            other_errors++;
            timed_out = 1'b1;
            $display("reset was never released");
        end
        for (int i = 0; i < frame_count && !timed_out; i++) begin
            run_frame(frame_table[i]);
        end
        repeat (20) @(negedge mipi_byte_clock);  // Stray deliveries still get caught
        $display("errors: pixel %0d, meter %0d, overflow %0d, other %0d",
                 pix_errors, meter_errors, flag_errors, other_errors);
        if (pix_errors + meter_errors + flag_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
camera_pkg.sv
csi2_packet_fsm.sv
raw10_unpacker.sv
raster_counter.sv
frame_metering.sv
credit_fifo.sv
camera_frontend.sv
tb_clock_gen.sv
camera_frontend_chk.sv
camera_frontend_tb.sv

// File: Bender.yml
package:
  name: camera_frontend

sources:
  - files:
      - camera_pkg.sv
      - csi2_packet_fsm.sv
      - raw10_unpacker.sv
      - raster_counter.sv
      - frame_metering.sv
      - credit_fifo.sv
      - camera_frontend.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - camera_frontend_chk.sv
      - camera_frontend_tb.sv
